// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= udp_tx_tb
SEED      ?= 64
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS := $(wildcard src/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# The seed is built into the binary, so a new SEED needs a clean build.
$(OBJ_DIR)/V%: $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $* -GSEED=$(SEED) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$*

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/udp_tx_properties.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "udp_tx_defines.svh"

module udp_tx_properties import udp_tx_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  tx_vld,
    input logic  tx_rdy,
    input logic  dfifo_wr,
    input logic  dfifo_rd,
    input word_t dout,
    input logic  dout_sop,
    input logic  dout_eop,
    input logic  dout_mty,
    input logic  dout_vld,
    input logic  dout_rdy
);
    logic [7:0] occupancy; // Data FIFO fill level seen from its enables.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupancy <= '0;
        end else if (dfifo_wr && !dfifo_rd) begin
            occupancy <= occupancy + 8'd1;
        end else if (dfifo_rd && !dfifo_wr) begin
            occupancy <= occupancy - 8'd1;
        end
    end

    dout_holds: assert property (@(posedge clk) disable iff (!rst_n)
        dout_vld && !dout_rdy |=> dout_vld && $stable(dout) && $stable(dout_sop)
                                  && $stable(dout_eop) && $stable(dout_mty))
        else $error("dout changed while the output was stalled");

    no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        tx_vld && tx_rdy |-> occupancy < 8'(`UDP_DATA_FIFO_DEPTH))
        else $error("input word accepted while the data FIFO was full");

    flags_need_valid: assert property (@(posedge clk) disable iff (!rst_n)
        dout_sop || dout_eop |-> dout_vld)
        else $error("dout_sop or dout_eop set without dout_vld");

    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !tx_rdy && !dout_vld)
        else $error("tx_rdy or dout_vld high right after reset");

endmodule

`default_nettype wire

// ==== dv/udp_tx_tb.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "udp_tx_defines.svh"

module udp_tx_tb import udp_tx_pkg::*; #(
    parameter int SEED = 64
);
    localparam int MAX_WORDS   = `UDP_MAX_PAYLOAD_WORDS;
    localparam int NUM_PKTS    = 1 + 10 + 4 + 20 + 50 + 3;
    localparam int CYCLE_LIMIT = NUM_PKTS * 4 * (MAX_WORDS + `UDP_HDR_WORDS + 3) + 1000;

    logic  clk;
    logic  rst_n;
    mac_t  cfg_mac_d;
    mac_t  cfg_mac_s;
    ipv4_t cfg_sip;
    ipv4_t cfg_dip;
    port_t cfg_sport;
    port_t cfg_dport;
    word_t tx_data;
    logic  tx_sop;
    logic  tx_eop;
    logic  tx_mty;
    logic  tx_vld;
    logic  tx_rdy;
    word_t dout;
    logic  dout_sop;
    logic  dout_eop;
    logic  dout_mty;
    logic  dout_vld;
    logic  dout_rdy;

    integer seed;
    integer rdy_seed;
    int     rdy_mode;     // 0 holds dout_rdy low, 1 holds it high, 2 throttles it.
    int     errors;
    int     checks;
    int     tests;
    int     tests_failed;
    int     cycles;
    word_t  model_id;
    word_t  pkt_words[$];
    word_t  exp_data[$];
    int     exp_pos[$];
    bit     exp_sop[$];
    bit     exp_eop[$];
    bit     exp_mty[$];

    udp_tx_top udp_tx_top_inst (.*);

    bind udp_tx_top udp_tx_properties udp_tx_properties_inst (
        .clk(clk), .rst_n(rst_n), .tx_vld(tx_vld), .tx_rdy(tx_rdy),
        .dfifo_wr(dfifo_wr), .dfifo_rd(dfifo_rd), .dout(dout), .dout_sop(dout_sop),
        .dout_eop(dout_eop), .dout_mty(dout_mty), .dout_vld(dout_vld), .dout_rdy(dout_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (rdy_mode == 2) begin
                dout_rdy = ($unsigned($random(rdy_seed)) % 100) < 70;
            end else begin
                dout_rdy = (rdy_mode == 1);
            end
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERR t=%0t %s expected 0x%04h got 0x%04h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input bit got, input bit exp);
        checks++;
        if (got !== exp) begin
            $display("ERR t=%0t %s expected %0b got %0b", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_len(input string name, input len_t got, input len_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERR t=%0t %s expected %0d got %0d", $time, name, exp, got);
            errors++;
        end
    endtask

    function automatic word_t fold_sum(input logic [31:0] s);
        logic [31:0] t;
        t = s;
        while (t[31:16] != 16'd0) begin
            t = {16'd0, t[15:0]} + {16'd0, t[31:16]};
        end
        return t[15:0];
    endfunction

    task automatic push_word(input word_t w, input int pos, input bit sop, input bit eop,
                             input bit mty);
        exp_data.push_back(w);
        exp_pos.push_back(pos);
        exp_sop.push_back(sop);
        exp_eop.push_back(eop);
        exp_mty.push_back(mty);
    endtask

    // Builds the whole frame that the DUT must send for the packet in pkt_words.
    task automatic queue_expected(input bit odd);
        word_t       hdr [`UDP_HDR_WORDS];
        logic [31:0] acc;
        len_t        bytes;
        word_t       udp_chk;
        int          n;
        int          i;
        n       = pkt_words.size();
        bytes   = len_t'(2 * n - (odd ? 1 : 0));
        hdr[0]  = cfg_mac_d[47:32];
        hdr[1]  = cfg_mac_d[31:16];
        hdr[2]  = cfg_mac_d[15:0];
        hdr[3]  = cfg_mac_s[47:32];
        hdr[4]  = cfg_mac_s[31:16];
        hdr[5]  = cfg_mac_s[15:0];
        hdr[6]  = 16'h0800;
        hdr[7]  = 16'h4500;
        hdr[8]  = bytes + 16'd28;
        hdr[9]  = model_id;
        hdr[10] = 16'h0000;
        hdr[11] = 16'hFF11;       // TTL 255, protocol 17.
        hdr[13] = cfg_sip[31:16];
        hdr[14] = cfg_sip[15:0];
        hdr[15] = cfg_dip[31:16];
        hdr[16] = cfg_dip[15:0];
        hdr[17] = cfg_sport;
        hdr[18] = cfg_dport;
        hdr[19] = bytes + 16'd8;
        acc = 32'd0;
        for (i = 7; i <= 16; i++) begin
            if (i != 12) begin
                acc += {16'd0, hdr[i]};
            end
        end
        hdr[12] = ~fold_sum(acc);
        acc = 32'h0000_0011 + {16'd0, hdr[19]}; // Pseudo header protocol and length.
        for (i = 13; i <= 19; i++) begin
            acc += {16'd0, hdr[i]};
        end
        for (i = 0; i < n; i++) begin
            if (odd && (i == n - 1)) begin
                acc += {16'd0, pkt_words[i][15:8], 8'h00}; // The empty low byte adds zero.
            end else begin
                acc += {16'd0, pkt_words[i]};
            end
        end
        udp_chk = ~fold_sum(acc);
        hdr[20] = (udp_chk == 16'h0000) ? 16'hFFFF : udp_chk;
        for (i = 0; i < `UDP_HDR_WORDS; i++) begin
            push_word(hdr[i], i, i == 0, 1'b0, 1'b0);
        end
        for (i = 0; i < n; i++) begin
            push_word(pkt_words[i], `UDP_HDR_WORDS + i, 1'b0, i == n - 1, odd && (i == n - 1));
        end
        model_id++;
    endtask

    task automatic check_output();
        word_t w;
        int    pos;
        if (exp_data.size() == 0) begin
            $display("Output word 0x%04h at %0t came with no packet expected", dout, $time);
            errors++;
        end else begin
            w   = exp_data.pop_front();
            pos = exp_pos.pop_front();
            case (pos)
                8:       check_len("ip_total_len", dout, w);
                9:       check_word("ip_id", dout, w);
                12:      check_word("ip_csum", dout, w);
                19:      check_len("udp_len", dout, w);
                20:      check_word("udp_csum", dout, w);
                default: check_word("dout", dout, w);
            endcase
            check_flag("dout_sop", dout_sop, exp_sop.pop_front());
            check_flag("dout_eop", dout_eop, exp_eop.pop_front());
            check_flag("dout_mty", dout_mty, exp_mty.pop_front());
        end
    endtask

    // Both sides of the output handshake are settled at the falling edge.
    always @(negedge clk) begin
        if (rst_n && dout_vld && dout_rdy) begin
            check_output();
        end
    end

    task automatic set_config();
        cfg_mac_d = mac_t'({$random(seed), $random(seed)});
        cfg_mac_s = mac_t'({$random(seed), $random(seed)});
        cfg_sip   = ipv4_t'($random(seed));
        cfg_dip   = ipv4_t'($random(seed));
        cfg_sport = port_t'($random(seed));
        cfg_dport = port_t'($random(seed));
    endtask

    task automatic send_packet(input int n, input bit odd, input int vld_pct);
        int i;
        bit accepted;
        pkt_words.delete();
        for (i = 0; i < n; i++) begin
            pkt_words.push_back(word_t'($random(seed)));
        end
        i = 0;
        while (i < n) begin
            tx_vld  = ($unsigned($random(seed)) % 100) < vld_pct;
            tx_data = pkt_words[i];
            tx_sop  = (i == 0);
            tx_eop  = (i == n - 1);
            tx_mty  = odd && (i == n - 1);
            @(negedge clk);
            accepted = tx_vld && tx_rdy;
            @(posedge clk);
            #1;
            if (accepted) begin
                i++;
            end
        end
        tx_vld = 1'b0;
        tx_sop = 1'b0;
        tx_eop = 1'b0;
        tx_mty = 1'b0;
        queue_expected(odd);
    endtask

    task automatic drain();
        while (exp_data.size() != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic report_test(input string name, input int err_start);
        tests++;
        if (errors == err_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - err_start);
        end
    endtask

    // len_mode 0 picks mty at random, 1 sends even lengths, 2 sends odd lengths.
    task automatic run_packets(input string name, input int npkts, input int len_mode,
                               input int vld_pct, input int rdy_m);
        int err_start;
        int p;
        int n;
        bit odd;
        err_start = errors;
        set_config();
        rdy_mode = rdy_m;
        for (p = 0; p < npkts; p++) begin
            n   = 1 + int'($unsigned($random(seed)) % MAX_WORDS);
            odd = (len_mode == 0) ? $random(seed) % 2 != 0 : (len_mode == 2);
            send_packet(n, odd, vld_pct);
        end
        drain();
        report_test(name, err_start);
    endtask

    task automatic stall_test();
        int err_start;
        bit stalled;
        int p;
        err_start = errors;
        stalled   = 1'b0;
        set_config();
        rdy_mode = 0;
        fork
            for (p = 0; p < 3; p++) begin
                send_packet(MAX_WORDS, 1'b0, 100);
            end
            begin
                repeat (200) @(negedge clk);
                stalled  = tx_vld && !tx_rdy;
                rdy_mode = 1;
            end
        join
        if (!stalled) begin
            $display("Input stall: tx_rdy was still high after the output had been held off");
            errors++;
        end
        drain();
        report_test("input_stall", err_start);
    endtask

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Verification failed");
        $finish;
    end

    initial begin
        seed         = SEED;
        rdy_seed     = SEED + 1;
        rdy_mode     = 1;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        tests_failed = 0;
        model_id     = '0;
        rst_n        = 1'b0;
        cfg_mac_d    = '0;
        cfg_mac_s    = '0;
        cfg_sip      = '0;
        cfg_dip      = '0;
        cfg_sport    = '0;
        cfg_dport    = '0;
        tx_data      = '0;
        tx_sop       = 1'b0;
        tx_eop       = 1'b0;
        tx_mty       = 1'b0;
        tx_vld       = 1'b0;
        dout_rdy     = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        run_packets("single_packet", 1, 1, 100, 1);
        run_packets("checksums", 10, 0, 100, 1);
        run_packets("odd_length", 4, 2, 100, 1);
        run_packets("identification", 20, 0, 100, 1);
        run_packets("back_pressure", 50, 0, 70, 2);
        stall_test();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/header_builder.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "udp_tx_defines.svh"

module header_builder import udp_tx_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hdr_load,
    input  msg_t     msg,
    input  word_t    ip_id,
    input  mac_t     cfg_mac_d,
    input  mac_t     cfg_mac_s,
    input  ipv4_t    cfg_sip,
    input  ipv4_t    cfg_dip,
    input  port_t    cfg_sport,
    input  port_t    cfg_dport,
    input  hdr_idx_t hdr_idx,
    output word_t    hdr_word
);
    msg_t  msg_q;
    word_t id_q;
    mac_t  mac_d_q;
    mac_t  mac_s_q;
    ipv4_t sip_q;
    ipv4_t dip_q;
    port_t sport_q;
    port_t dport_q;
    len_t  ip_len;
    len_t  udp_len;
    csum_t ip_sum;
    csum_t udp_sum;
    word_t ip_chk;
    word_t udp_chk;

    function automatic csum_t csum_add(csum_t a, word_t b);
        logic [16:0] s;
        s = {1'b0, a} + {1'b0, b};
        return s[15:0] + {15'd0, s[16]};
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            msg_q   <= '0;
            id_q    <= '0;
            mac_d_q <= '0;
            mac_s_q <= '0;
            sip_q   <= '0;
            dip_q   <= '0;
            sport_q <= '0;
            dport_q <= '0;
        end else if (hdr_load) begin
            msg_q   <= msg;
            id_q    <= ip_id;
            mac_d_q <= cfg_mac_d;
            mac_s_q <= cfg_mac_s;
            sip_q   <= cfg_sip;
            dip_q   <= cfg_dip;
            sport_q <= cfg_sport;
            dport_q <= cfg_dport;
        end
    end

    assign udp_len = msg_q[15:0] + 16'd8;
    assign ip_len  = msg_q[15:0] + 16'd28; // IP and UDP headers on top of the payload.

    always_comb begin
        // Flags and fragment offset are zero and drop out of the sum.
        ip_sum = {`UDP_IP_VER_IHL, 8'h00};
        ip_sum = csum_add(ip_sum, ip_len);
        ip_sum = csum_add(ip_sum, id_q);
        ip_sum = csum_add(ip_sum, {`UDP_IP_TTL, `UDP_IP_PROTO});
        ip_sum = csum_add(ip_sum, sip_q[31:16]);
        ip_sum = csum_add(ip_sum, sip_q[15:0]);
        ip_sum = csum_add(ip_sum, dip_q[31:16]);
        ip_sum = csum_add(ip_sum, dip_q[15:0]);
        ip_chk = ~ip_sum;
    end

    always_comb begin
        udp_sum = msg_q[31:16];
        udp_sum = csum_add(udp_sum, sip_q[31:16]);
        udp_sum = csum_add(udp_sum, sip_q[15:0]);
        udp_sum = csum_add(udp_sum, dip_q[31:16]);
        udp_sum = csum_add(udp_sum, dip_q[15:0]);
        udp_sum = csum_add(udp_sum, {8'h00, `UDP_IP_PROTO});
        udp_sum = csum_add(udp_sum, udp_len);
        udp_sum = csum_add(udp_sum, sport_q);
        udp_sum = csum_add(udp_sum, dport_q);
        udp_sum = csum_add(udp_sum, udp_len);
        udp_chk = (udp_sum == 16'hFFFF) ? 16'hFFFF : ~udp_sum; // Zero means no checksum.
    end

    always_comb begin
        case (hdr_idx)
            5'd0:    hdr_word = mac_d_q[47:32];
            5'd1:    hdr_word = mac_d_q[31:16];
            5'd2:    hdr_word = mac_d_q[15:0];
            5'd3:    hdr_word = mac_s_q[47:32];
            5'd4:    hdr_word = mac_s_q[31:16];
            5'd5:    hdr_word = mac_s_q[15:0];
            5'd6:    hdr_word = `UDP_ETH_TYPE_IPV4;
            5'd7:    hdr_word = {`UDP_IP_VER_IHL, 8'h00};
            5'd8:    hdr_word = ip_len;
            5'd9:    hdr_word = id_q;
            5'd10:   hdr_word = 16'h0000;
            5'd11:   hdr_word = {`UDP_IP_TTL, `UDP_IP_PROTO};
            5'd12:   hdr_word = ip_chk;
            5'd13:   hdr_word = sip_q[31:16];
            5'd14:   hdr_word = sip_q[15:0];
            5'd15:   hdr_word = dip_q[31:16];
            5'd16:   hdr_word = dip_q[15:0];
            5'd17:   hdr_word = sport_q;
            5'd18:   hdr_word = dport_q;
            5'd19:   hdr_word = udp_len;
            5'd20:   hdr_word = udp_chk;
            default: hdr_word = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/payload_summer.sv ====
`default_nettype none
`timescale 1ns/1ps

module payload_summer import udp_tx_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  word_t tx_data,
    input  logic  tx_sop,
    input  logic  tx_eop,
    input  logic  tx_mty,
    input  logic  tx_vld,
    output logic  tx_rdy,
    input  logic  dfifo_almost_full,
    input  logic  mfifo_full,
    output logic  dfifo_wr,
    output logic  mfifo_wr,
    output msg_t  msg
);
    logic        xfer;
    logic        half_word;
    len_t        byte_cnt;
    csum_t       sum;
    len_t        cnt_base;
    csum_t       sum_base;
    word_t       add_word;
    logic [16:0] sum_raw;
    len_t        cnt_next;
    csum_t       sum_next;

    assign xfer      = tx_vld & tx_rdy;
    assign half_word = tx_eop & tx_mty;
    assign dfifo_wr  = xfer;
    assign mfifo_wr  = xfer & tx_eop;

    // A start word always opens a fresh packet.
    assign cnt_base = tx_sop ? '0 : byte_cnt;
    assign sum_base = tx_sop ? '0 : sum;

    assign add_word = half_word ? {tx_data[15:8], 8'h00} : tx_data;
    assign sum_raw  = {1'b0, sum_base} + {1'b0, add_word};
    assign sum_next = sum_raw[15:0] + {15'd0, sum_raw[16]}; // End-around carry.
    assign cnt_next = cnt_base + (half_word ? 16'd1 : 16'd2);

    assign msg = {sum_next, cnt_next};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt <= '0;
            sum      <= '0;
        end else if (xfer) begin
            if (tx_eop) begin
                byte_cnt <= '0;
                sum      <= '0;
            end else begin
                byte_cnt <= cnt_next;
                sum      <= sum_next;
            end
        end
    end

    // A summary written this cycle is not yet seen by mfifo_full,
    // so it holds the input off for a cycle as well.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_rdy <= 1'b0;
        end else begin
            tx_rdy <= ~dfifo_almost_full & ~mfifo_full & ~mfifo_wr;
        end
    end

endmodule

`default_nettype wire

// ==== src/stream_fifo.sv ====
`default_nettype none
`timescale 1ns/1ps

module stream_fifo #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             empty,
    output logic             full,
    output logic             almost_full
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [CW-1:0] AF_LEVEL = CW'(DEPTH - 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr       = wr_en & ~full;
    assign do_rd       = rd_en & ~empty;
    assign empty       = (count == '0);
    assign full        = (count == CW'(DEPTH));
    assign almost_full = (count >= AF_LEVEL); // One entry or none left.
    assign rd_data     = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/tx_pack.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "udp_tx_defines.svh"

module tx_pack import udp_tx_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mfifo_empty,
    output logic        mfifo_rd,
    input  logic        dfifo_empty,
    input  logic [17:0] dfifo_q,
    output logic        dfifo_rd,
    output logic        hdr_load,
    output word_t       ip_id,
    output hdr_idx_t    hdr_idx,
    input  word_t       hdr_word,
    output word_t       dout,
    output logic        dout_sop,
    output logic        dout_eop,
    output logic        dout_mty,
    output logic        dout_vld,
    input  logic        dout_rdy
);
    localparam hdr_idx_t LAST_IDX = hdr_idx_t'(`UDP_HDR_WORDS - 1);

    seq_state_t state;
    logic       load_ok;
    logic       last_held;
    logic       head_take;
    logic       data_take;

    assign load_ok   = ~dout_vld | dout_rdy; // Output stage empty or being accepted.
    assign last_held = dout_vld & dout_eop;
    assign head_take = (state == SEQ_HEAD) & load_ok;
    assign data_take = (state == SEQ_DATA) & load_ok & ~last_held & ~dfifo_empty;

    assign dfifo_rd = data_take;
    assign mfifo_rd = (state == SEQ_LOAD) & ~mfifo_empty;
    assign hdr_load = (state == SEQ_LOAD);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= SEQ_IDLE;
            hdr_idx  <= '0;
            ip_id    <= '0;
            dout_vld <= 1'b0;
            dout_sop <= 1'b0;
            dout_eop <= 1'b0;
            dout_mty <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (!mfifo_empty) begin
                        state <= SEQ_LOAD;
                    end
                end
                SEQ_LOAD: begin
                    state <= SEQ_HEAD;
                end
                SEQ_HEAD: begin
                    if (load_ok) begin
                        dout_vld <= 1'b1;
                        dout_sop <= (hdr_idx == '0);
                        dout_eop <= 1'b0;
                        dout_mty <= 1'b0;
                        if (hdr_idx == LAST_IDX) begin
                            hdr_idx <= '0;
                            state   <= SEQ_DATA;
                        end else begin
                            hdr_idx <= hdr_idx + 1'b1;
                        end
                    end
                end
                SEQ_DATA: begin
                    if (last_held) begin
                        if (dout_rdy) begin
                            dout_vld <= 1'b0;
                            dout_eop <= 1'b0;
                            dout_mty <= 1'b0;
                            state    <= SEQ_IDLE;
                        end
                    end else if (load_ok) begin
                        dout_sop <= 1'b0;
                        dout_vld <= ~dfifo_empty;
                        dout_eop <= ~dfifo_empty & dfifo_q[17];
                        dout_mty <= ~dfifo_empty & dfifo_q[17] & dfifo_q[16];
                        if (!dfifo_empty && dfifo_q[17]) begin
                            ip_id <= ip_id + 1'b1;
                        end
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (head_take) begin
            dout <= hdr_word;
        end else if (data_take) begin
            dout <= dfifo_q[15:0];
        end
    end

endmodule

`default_nettype wire

// ==== src/udp_tx_defines.svh ====
`ifndef UDP_TX_DEFINES_SVH
`define UDP_TX_DEFINES_SVH

`define UDP_DATA_FIFO_DEPTH   64
`define UDP_MSG_FIFO_DEPTH    4

// A whole payload has to fit in the data FIFO before its header can start.
`define UDP_MAX_PAYLOAD_WORDS `UDP_DATA_FIFO_DEPTH

`define UDP_ETH_WORDS         7
`define UDP_IP_WORDS          10
`define UDP_UDP_WORDS         4
`define UDP_HDR_WORDS         (`UDP_ETH_WORDS + `UDP_IP_WORDS + `UDP_UDP_WORDS)

`define UDP_IP_VER_IHL        8'h45
`define UDP_IP_TTL            8'd255
`define UDP_IP_PROTO          8'd17
`define UDP_ETH_TYPE_IPV4     16'h0800

`endif

// ==== src/udp_tx_pkg.sv ====
`default_nettype none

package udp_tx_pkg;

    typedef logic [15:0] word_t;
    typedef logic [15:0] len_t;
    typedef logic [15:0] csum_t;
    typedef logic [47:0] mac_t;
    typedef logic [31:0] ipv4_t;
    typedef logic [15:0] port_t;
    typedef logic [4:0]  hdr_idx_t;

    // Upper half is the payload sum, lower half the byte length.
    typedef logic [31:0] msg_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_LOAD,
        SEQ_HEAD,
        SEQ_DATA
    } seq_state_t;

endpackage

`default_nettype wire

// ==== src/udp_tx_top.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "udp_tx_defines.svh"

module udp_tx_top import udp_tx_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  mac_t  cfg_mac_d,
    input  mac_t  cfg_mac_s,
    input  ipv4_t cfg_sip,
    input  ipv4_t cfg_dip,
    input  port_t cfg_sport,
    input  port_t cfg_dport,
    input  word_t tx_data,
    input  logic  tx_sop,
    input  logic  tx_eop,
    input  logic  tx_mty,
    input  logic  tx_vld,
    output logic  tx_rdy,
    output word_t dout,
    output logic  dout_sop,
    output logic  dout_eop,
    output logic  dout_mty,
    output logic  dout_vld,
    input  logic  dout_rdy
);
    logic        dfifo_wr;
    logic        dfifo_rd;
    logic [17:0] dfifo_q;
    logic        dfifo_empty;
    logic        dfifo_almost_full;
    logic        mfifo_wr;
    logic        mfifo_rd;
    msg_t        mfifo_data;
    msg_t        mfifo_q;
    logic        mfifo_empty;
    logic        mfifo_full;
    logic        hdr_load;
    word_t       ip_id;
    hdr_idx_t    hdr_idx;
    word_t       hdr_word;

    stream_fifo #(
        .WIDTH (18),
        .DEPTH (`UDP_DATA_FIFO_DEPTH)
    ) data_fifo_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (dfifo_wr),
        .wr_data     ({tx_eop, tx_eop & tx_mty, tx_data}),
        .rd_en       (dfifo_rd),
        .rd_data     (dfifo_q),
        .empty       (dfifo_empty),
        .full        (),
        .almost_full (dfifo_almost_full)
    );

    stream_fifo #(
        .WIDTH ($bits(msg_t)),
        .DEPTH (`UDP_MSG_FIFO_DEPTH)
    ) msg_fifo_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (mfifo_wr),
        .wr_data     (mfifo_data),
        .rd_en       (mfifo_rd),
        .rd_data     (mfifo_q),
        .empty       (mfifo_empty),
        .full        (mfifo_full),
        .almost_full ()
    );

    payload_summer payload_summer_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .tx_data           (tx_data),
        .tx_sop            (tx_sop),
        .tx_eop            (tx_eop),
        .tx_mty            (tx_mty),
        .tx_vld            (tx_vld),
        .tx_rdy            (tx_rdy),
        .dfifo_almost_full (dfifo_almost_full),
        .mfifo_full        (mfifo_full),
        .dfifo_wr          (dfifo_wr),
        .mfifo_wr          (mfifo_wr),
        .msg               (mfifo_data)
    );

    header_builder header_builder_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .hdr_load  (hdr_load),
        .msg       (mfifo_q),
        .ip_id     (ip_id),
        .cfg_mac_d (cfg_mac_d),
        .cfg_mac_s (cfg_mac_s),
        .cfg_sip   (cfg_sip),
        .cfg_dip   (cfg_dip),
        .cfg_sport (cfg_sport),
        .cfg_dport (cfg_dport),
        .hdr_idx   (hdr_idx),
        .hdr_word  (hdr_word)
    );

    tx_pack tx_pack_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .mfifo_empty (mfifo_empty),
        .mfifo_rd    (mfifo_rd),
        .dfifo_empty (dfifo_empty),
        .dfifo_q     (dfifo_q),
        .dfifo_rd    (dfifo_rd),
        .hdr_load    (hdr_load),
        .ip_id       (ip_id),
        .hdr_idx     (hdr_idx),
        .hdr_word    (hdr_word),
        .dout        (dout),
        .dout_sop    (dout_sop),
        .dout_eop    (dout_eop),
        .dout_mty    (dout_mty),
        .dout_vld    (dout_vld),
        .dout_rdy    (dout_rdy)
    );

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+src
src/udp_tx_pkg.sv
src/stream_fifo.sv
src/payload_summer.sv
src/header_builder.sv
src/tx_pack.sv
src/udp_tx_top.sv
dv/udp_tx_properties.sv
dv/udp_tx_tb.sv
